// ==== rtl/bldc_pkg.sv ====
// ======================================================================
// BLDC controller package
// Widths, PWM and dead-time constants, the hall sequence, the
// commutation table and the duty command word shared by the blocks
// ======================================================================
package bldc_pkg;

    // ==================================================================
    // Widths
    // ==================================================================
    localparam int duty_w       = 10;   // Duty command word
    localparam int mag_w        = 9;    // Duty magnitude
    localparam int enc_count_w  = 15;
    localparam int hall_count_w = 7;

    // ==================================================================
    // PWM timing
    // ==================================================================
    localparam int pwm_max     = 511;  // Counter runs 0..pwm_max, 512 cycle period
    localparam int dead_time   = 10;   // Cycles between one side off and the other on
    localparam int dead_time_w = $clog2(dead_time + 1);

    // Phase index, also the bit position in phase_h and phase_l
    localparam logic [1:0] phase_a    = 2'd0;
    localparam logic [1:0] phase_b    = 2'd1;
    localparam logic [1:0] phase_c    = 2'd2;
    localparam logic [1:0] phase_none = 2'd3;  // No phase selected

    // ==================================================================
    // Hall decoding
    // ==================================================================
    // Forward rotation order of the six legal codes
    // Neighbours sit on either side, wrapping at the ends
    localparam logic [2:0] hall_seq [0:5] = '{
        3'd1, 3'd3, 3'd2, 3'd6, 3'd4, 3'd5
    };

    // Indexed by hall code, forward direction
    // Bits 3:2 source phase, bits 1:0 sink phase
    localparam logic [3:0] comm_table [0:7] = '{
        {phase_none, phase_none},   // 0 is not a legal code
        {phase_a,    phase_b},      // 1
        {phase_b,    phase_c},      // 2
        {phase_a,    phase_c},      // 3
        {phase_c,    phase_a},      // 4
        {phase_c,    phase_b},      // 5
        {phase_b,    phase_a},      // 6
        {phase_none, phase_none}    // 7 is not a legal code
    };

    // ==================================================================
    // Duty command
    // ==================================================================
    // Top bit is the direction, 1 runs forward
    typedef union packed {
        logic [duty_w-1:0] raw;
        struct packed {
            logic             dir;
            logic [mag_w-1:0] mag;
        } cmd;
    } duty_cmd_t;

endpackage

// ==== rtl/hall_bus_if.sv ====
// ======================================================================
// Hall bus
// Decoded rotor sector and hall health, carried from the hall monitor
// to the phase driver as plain levels and a one-cycle step pulse
// ======================================================================
interface hall_bus_if (
    input logic clk
);

    logic [2:0] code;        // Registered hall code
    logic       valid;       // Code is 1 to 6
    logic       connected;   // Valid, seen since enable and no fault
    logic       fault;       // Sticky until en drops
    logic       edge_pulse;  // One cycle per step to a neighbour

    // Monitor side
    modport mon (input clk, output code, valid, connected, fault, edge_pulse);

    // Driver side
    modport drv (input clk, input code, valid, connected, fault, edge_pulse);

endinterface

// ==== rtl/hall_monitor.sv ====
// ======================================================================
// Hall monitor
// Synchronizes the three hall lines, decodes the rotor sector, flags
// illegal codes and skipped sectors, and counts valid hall steps
// ======================================================================
module hall_monitor (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              en,
    input  logic                              reset_hall_count,
    input  logic [2:0]                        hall,
    output logic [bldc_pkg::hall_count_w-1:0] hall_count,
    hall_bus_if.mon                           bus
);
    import bldc_pkg::*;

    logic [2:0] hall_s1;      // Synchronizer first stage
    logic [2:0] hall_s2;
    logic [2:0] code_q;       // Current sector code
    logic       valid_q;
    logic       edge_q;
    logic       fault_q;
    logic       seen_q;       // A legal code arrived since enable

    logic       nxt_valid;
    logic       changed;
    logic       neighbour;
    logic       step_ok;
    logic       step_bad;

    // Position of a code in the forward sequence
    function automatic logic [2:0] seq_pos(input logic [2:0] code);
        logic [2:0] pos;
        pos = 3'd0;
        for (int i = 0; i < 6; i++) begin
            if (hall_seq[i] == code) begin
                pos = 3'(i);
            end
        end
        return pos;
    endfunction

    // True when the two codes are adjacent in the rotation, either way
    function automatic logic is_neighbour(input logic [2:0] a, input logic [2:0] b);
        logic [2:0] pa;
        logic [2:0] pb;
        logic [2:0] pa_next;
        logic [2:0] pb_next;
        pa      = seq_pos(a);
        pb      = seq_pos(b);
        pa_next = (pa == 3'd5) ? 3'd0 : pa + 3'd1;
        pb_next = (pb == 3'd5) ? 3'd0 : pb + 3'd1;
        return (pb == pa_next) || (pa == pb_next);
    endfunction

    // ==================================================================
    // Step classification
    // ==================================================================
    assign nxt_valid = (hall_s2 != 3'd0) && (hall_s2 != 3'd7);
    assign changed   = (hall_s2 != code_q);
    assign neighbour = is_neighbour(code_q, hall_s2);

    assign step_ok  = changed && valid_q && nxt_valid && neighbour;
    assign step_bad = changed && ((valid_q && nxt_valid && !neighbour)   // Skipped a sector
                                  || (!nxt_valid && seen_q));            // Lost the sensor

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hall_s1 <= 3'd0;
            hall_s2 <= 3'd0;
        end else begin
            hall_s1 <= hall;
            hall_s2 <= hall_s1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            code_q  <= 3'd0;
            valid_q <= 1'b0;
            edge_q  <= 1'b0;
            fault_q <= 1'b0;
            seen_q  <= 1'b0;
        end else begin
            code_q  <= hall_s2;
            valid_q <= nxt_valid;
            edge_q  <= step_ok;   // Lines up with the new code
            if (!en) begin
                fault_q <= 1'b0;
                seen_q  <= 1'b0;
            end else begin
                if (step_bad) fault_q <= 1'b1;
                if (nxt_valid) seen_q <= 1'b1;
            end
        end
    end

    // Wraps at the counter width
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hall_count <= '0;
        end else if (reset_hall_count) begin
            hall_count <= '0;
        end else if (bus.edge_pulse) begin
            hall_count <= hall_count + 1'b1;
        end
    end

    assign bus.code       = code_q;
    assign bus.valid      = valid_q;
    assign bus.fault      = fault_q;
    assign bus.edge_pulse = edge_q;
    assign bus.connected  = valid_q & seen_q & ~fault_q;

    // A step pulse always lands on a fresh legal code
    a_edge_on_new_code: assert property (@(posedge clk) disable iff (!arst_n)
        bus.edge_pulse |-> bus.valid && (bus.code != $past(bus.code)));

endmodule

// ==== rtl/encoder_counter.sv ====
// ======================================================================
// Encoder counter
// Quadrature decoder with a two-flop synchronizer and a wrapping
// up/down count of encoder edges
// ======================================================================
module encoder_counter (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             reset_enc_count,
    input  logic [1:0]                       enc,
    output logic [bldc_pkg::enc_count_w-1:0] enc_count
);

    logic [1:0] enc_s1;     // Bit 0 is line A, bit 1 is line B
    logic [1:0] enc_s2;
    logic [1:0] enc_prev;   // Last decoded state
    logic       step;
    logic       step_up;

    // Gray code moves one line at a time, a double jump is dropped
    assign step    = ^(enc_s2 ^ enc_prev);
    assign step_up = enc_s2[0] ^ enc_prev[1];   // A leads B

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enc_s1   <= 2'b00;
            enc_s2   <= 2'b00;
            enc_prev <= 2'b00;
        end else begin
            enc_s1   <= enc;
            enc_s2   <= enc_s1;
            enc_prev <= enc_s2;
        end
    end

    // ==================================================================
    // Up/down count
    // ==================================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enc_count <= '0;
        end else if (reset_enc_count) begin
            enc_count <= '0;
        end else if (step) begin
            if (step_up) begin
                enc_count <= enc_count + 1'b1;
            end else begin
                enc_count <= enc_count - 1'b1;
            end
        end
    end

    // Counting never skips, even on a wrap
    a_count_step: assert property (@(posedge clk) disable iff (!arst_n)
        !reset_enc_count |=> (enc_count == $past(enc_count))
                             || (enc_count == $past(enc_count) + 1'b1)
                             || (enc_count == $past(enc_count) - 1'b1));

endmodule

// ==== rtl/phase_driver.sv ====
// ======================================================================
// Phase driver
// PWM generator with a soft-start duty ramp, six-step commutation
// from the hall sector and dead-time gaps on the switched phase
// ======================================================================
module phase_driver (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                en,
    input  bldc_pkg::duty_cmd_t duty_cycle,
    hall_bus_if.drv             bus,
    output logic [2:0]          phase_h,
    output logic [2:0]          phase_l
);
    import bldc_pkg::*;

    logic [mag_w-1:0]       pwm_cnt;
    logic [mag_w-1:0]       duty_q;      // Applied duty after the ramp
    logic                   dir_q;       // Direction for this period
    logic [dead_time_w-1:0] dt_cnt;      // Gap left after a high-side edge
    logic                   src_hi_q;

    logic       run;
    logic       period_end;
    logic       active;
    logic [3:0] comm;
    logic [1:0] src_ph;
    logic [1:0] snk_ph;
    logic [2:0] src_oh;
    logic [2:0] snk_oh;
    logic       src_hi_nxt;
    logic       src_lo_nxt;
    logic       hi_edge;
    logic       pre_rise;

    assign run        = en && !bus.fault;
    assign period_end = (pwm_cnt == mag_w'(pwm_max));
    assign active     = run && bus.valid && (duty_q != '0);

    // ==================================================================
    // PWM counter and soft start
    // ==================================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pwm_cnt <= '0;
        end else if (period_end) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    // One step per period toward the commanded magnitude
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            duty_q <= '0;
            dir_q  <= 1'b1;
        end else if (!run) begin
            duty_q <= '0;
            dir_q  <= duty_cycle.cmd.dir;   // Idle, safe to turn around
        end else if (period_end) begin
            dir_q <= duty_cycle.cmd.dir;
            if (duty_q < duty_cycle.cmd.mag) begin
                duty_q <= duty_q + 1'b1;
            end else if (duty_q > duty_cycle.cmd.mag) begin
                duty_q <= duty_q - 1'b1;
            end
        end
    end

    // ==================================================================
    // Commutation
    // ==================================================================
    assign comm   = comm_table[bus.code];
    assign src_ph = dir_q ? comm[3:2] : comm[1:0];   // Reverse swaps the pair
    assign snk_ph = dir_q ? comm[1:0] : comm[3:2];
    assign src_oh = 3'b001 << src_ph;
    assign snk_oh = 3'b001 << snk_ph;

    // ==================================================================
    // Source leg with dead time
    // ==================================================================
    assign src_hi_nxt = active && (pwm_cnt < duty_q);
    assign hi_edge    = (src_hi_nxt != src_hi_q);

    // Low side lets go ahead of the period start so the high side rises clean
    assign pre_rise   = (pwm_cnt > mag_w'(pwm_max - dead_time));

    assign src_lo_nxt = active && !src_hi_nxt && !hi_edge
                        && (dt_cnt == '0) && !pre_rise;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            src_hi_q <= 1'b0;
            dt_cnt   <= '0;
        end else begin
            src_hi_q <= src_hi_nxt;
            if (hi_edge) begin
                dt_cnt <= dead_time_w'(dead_time - 1);
            end else if (dt_cnt != '0) begin
                dt_cnt <= dt_cnt - 1'b1;
            end
        end
    end

    // Registered gates, one cycle behind the counter
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase_h <= 3'b000;
            phase_l <= 3'b000;
        end else begin
            phase_h <= src_hi_nxt ? src_oh : 3'b000;
            phase_l <= (src_lo_nxt ? src_oh : 3'b000)
                       | (active ? snk_oh : 3'b000);   // Sink held low
        end
    end

    // No leg ever shorts the supply
    a_no_shoot_through: assert property (@(posedge clk) disable iff (!arst_n)
        (phase_h & phase_l) == 3'b000);

endmodule

// ==== rtl/bldc_motor.sv ====
// ======================================================================
// BLDC motor controller
// Top level joining the hall monitor, the encoder counter and the
// phase driver of a three-phase brushless motor
// ======================================================================
module bldc_motor (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              en,
    input  logic                              reset_enc_count,
    input  logic                              reset_hall_count,
    input  logic [bldc_pkg::duty_w-1:0]       duty_cycle,   // Direction bit and magnitude
    input  logic [1:0]                        enc,
    input  logic [2:0]                        hall,
    output logic [2:0]                        phase_h,      // Bit 0 is phase A
    output logic [2:0]                        phase_l,
    output logic [bldc_pkg::enc_count_w-1:0]  enc_count,
    output logic [bldc_pkg::hall_count_w-1:0] hall_count,
    output logic                              connected
);

    // Sector and health straight to the driver, no queue in between
    hall_bus_if hall_bus (
        .clk (clk)
    );

    // ==================================================================
    // Sensors
    // ==================================================================
    hall_monitor hall_monitor_inst (
        .clk              (clk),
        .arst_n           (arst_n),
        .en               (en),
        .reset_hall_count (reset_hall_count),
        .hall             (hall),
        .hall_count       (hall_count),
        .bus              (hall_bus.mon)
    );

    encoder_counter encoder_counter_inst (
        .clk             (clk),
        .arst_n          (arst_n),
        .reset_enc_count (reset_enc_count),
        .enc             (enc),
        .enc_count       (enc_count)
    );

    // ==================================================================
    // Gate drive
    // ==================================================================
    phase_driver phase_driver_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .en         (en),
        .duty_cycle (duty_cycle),     // Read as the duty command union
        .bus        (hall_bus.drv),
        .phase_h    (phase_h),
        .phase_l    (phase_l)
    );

    assign connected = hall_bus.connected;

endmodule

// ==== dv/bldc_motor_tb.sv ====
// ======================================================================
// BLDC motor controller testbench
// Directed tests for reset, hall stepping and faults, encoder counting,
// commutation, soft-start duty and dead time on the gate outputs
// ======================================================================
module bldc_motor_tb;
    import bldc_pkg::*;

    logic                    clk;
    logic                    arst_n;
    logic                    en;
    logic                    reset_enc_count;
    logic                    reset_hall_count;
    logic [duty_w-1:0]       duty_cycle;
    logic [1:0]              enc;
    logic [2:0]              hall;
    logic [2:0]              phase_h;
    logic [2:0]              phase_l;
    logic [enc_count_w-1:0]  enc_count;
    logic [hall_count_w-1:0] hall_count;
    logic                    connected;

    logic [31:0] lfsr_state;
    logic [2:0]  prev_h;          // Gate monitor state per phase
    logic [2:0]  armed;           // High side fell and low side not yet on
    int          gap [3];
    int          falls_checked;

    bldc_motor bldc_motor_inst (
        .clk              (clk),
        .arst_n           (arst_n),
        .en               (en),
        .reset_enc_count  (reset_enc_count),
        .reset_hall_count (reset_hall_count),
        .duty_cycle       (duty_cycle),
        .enc              (enc),
        .hall             (hall),
        .phase_h          (phase_h),
        .phase_l          (phase_l),
        .enc_count        (enc_count),
        .hall_count       (hall_count),
        .connected        (connected)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==================================================================
    // Failure reporting and helpers
    // ==================================================================
    task automatic stop_run();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic value_error(input string test, input int expected, input int actual);
        $display("[ERROR] %s: expected %0d, actual %0d", test, expected, actual);
        stop_run();
    endtask

    task automatic text_error(input string what);
        $display("%s", what);
        stop_run();
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [2:0] source_gate(input logic [2:0] code, input logic dir);
        return 3'b001 << (dir ? comm_table[code][3:2] : comm_table[code][1:0]);
    endfunction

    function automatic logic [2:0] sink_gate(input logic [2:0] code, input logic dir);
        return 3'b001 << (dir ? comm_table[code][1:0] : comm_table[code][3:2]);
    endfunction

    // Quadrature states {B, A} in forward order where A leads B
    function automatic logic [1:0] quad_state(input int pos);
        case (pos)
            0:       return 2'b00;
            1:       return 2'b01;
            2:       return 2'b11;
            default: return 2'b10;
        endcase
    endfunction

    // Waits until the high sides show exactly the wanted gates
    task automatic wait_gates(input logic [2:0] want, input string test);
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (phase_h != want && t < 3 * (pwm_max + 1));
        assert (phase_h == want) else value_error(test, want, phase_h);
    endtask

    // High-side cycles over one PWM period starting at the current sample
    task automatic measure_on_time(input logic [2:0] src, output int on_time);
        on_time = 0;
        repeat (pwm_max + 1) begin
            if ((phase_h & src) != 3'b000) on_time++;
            @(negedge clk);
        end
    endtask

    task automatic check_idle(input string test);
        assert (phase_h == 3'b000) else value_error(test, 0, phase_h);
        assert (phase_l == 3'b000) else value_error(test, 0, phase_l);
        assert (!connected) else value_error(test, 0, connected);
    endtask

    // ==================================================================
    // Gate monitor running through every test
    // ==================================================================
    always @(negedge clk) begin
        if (!arst_n) begin
            armed         = 3'b000;
            gap           = '{0, 0, 0};
            falls_checked = 0;
        end else begin
            assert ((phase_h & phase_l) == 3'b000)
                else value_error("shoot_through", 0, phase_h & phase_l);
            for (int p = 0; p < 3; p++) begin
                if (phase_h[p]) begin
                    armed[p] = 1'b0;
                end else begin
                    if (prev_h[p]) begin      // First cycle after a fall
                        armed[p] = 1'b1;
                        gap[p]   = 0;
                    end
                    if (armed[p] && phase_l[p]) begin
                        assert (gap[p] >= dead_time)
                            else value_error("dead_time", dead_time, gap[p]);
                        armed[p] = 1'b0;
                        falls_checked++;
                    end else if (armed[p]) begin
                        gap[p]++;
                    end
                end
            end
        end
        prev_h = phase_h;
    end

    // ==================================================================
    // Tests
    // ==================================================================
    task automatic verify_reset_disable();
        @(negedge clk);
        check_idle("reset_disable");
        assert (enc_count == '0) else value_error("reset_disable enc_count", 0, enc_count);
        assert (hall_count == '0) else value_error("reset_disable hall_count", 0, hall_count);
        @(posedge clk);
        duty_cycle <= {1'b1, 9'd40};   // Nonzero command while en stays low
        hall       <= hall_seq[0];
        repeat (2 * (pwm_max + 1)) begin
            @(negedge clk);
            check_idle("reset_disable");
        end
    endtask

    task automatic step_hall_sensors();
        int pos;
        int t;
        logic [2:0] jump;
        @(posedge clk);
        en               <= 1'b1;
        duty_cycle       <= {1'b1, 9'd0};
        reset_hall_count <= 1'b1;
        @(posedge clk);
        reset_hall_count <= 1'b0;
        pos = 0;
        for (int s = 0; s < 20; s++) begin
            pos = (pos + 1) % 6;
            @(posedge clk);
            hall <= hall_seq[pos];
            t = 0;
            while (hall_count != s + 1 && t < 10) begin
                @(negedge clk);
                t++;
            end
            assert (hall_count == s + 1)
                else value_error("hall_stepping count", s + 1, hall_count);
        end
        @(negedge clk);
        assert (connected) else value_error("hall_stepping connected", 1, connected);
        @(posedge clk);
        duty_cycle <= {1'b1, 9'd2};
        wait_gates(source_gate(hall_seq[pos], 1'b1), "hall_stepping drive");

        // Skip three sectors ahead
        jump = hall_seq[(pos + 3) % 6];
        @(posedge clk);
        hall <= jump;
        t = 0;
        while (connected && t < 10) begin
            @(negedge clk);
            t++;
        end
        @(negedge clk);
        repeat (pwm_max + 1) begin
            @(negedge clk);
            check_idle("hall_stepping fault");
        end
        @(posedge clk);
        en <= 1'b0;
        @(posedge clk);
        en <= 1'b1;
        t = 0;
        while (!connected && t < 10) begin
            @(negedge clk);
            t++;
        end
        assert (connected) else value_error("hall_stepping recover", 1, connected);
        assert (hall_count == 20) else value_error("hall_stepping jump count", 20, hall_count);

        @(posedge clk);
        hall <= 3'd0;
        t = 0;
        while (connected && t < 10) begin
            @(negedge clk);
            t++;
        end
        assert (!connected) else value_error("hall_stepping code 0", 0, connected);
    endtask

    task automatic count_encoder_steps();
        logic [enc_count_w-1:0] model;
        logic [31:0]            r;
        int                     qpos;
        int                     t;
        model = '0;
        qpos  = 0;
        for (int i = 0; i < 300; i++) begin
            r = rand_bits(1);
            if (r[0]) begin
                qpos  = (qpos + 1) % 4;
                model = model + 1'b1;
            end else begin
                qpos  = (qpos + 3) % 4;
                model = model - 1'b1;
            end
            @(posedge clk);
            enc <= quad_state(qpos);
            @(posedge clk);
        end
        t = 0;
        while (enc_count != model && t < 10) begin
            @(negedge clk);
            t++;
        end
        assert (enc_count == model) else value_error("encoder count", model, enc_count);
        @(posedge clk);
        reset_enc_count <= 1'b1;
        @(posedge clk);
        reset_enc_count <= 1'b0;
        @(negedge clk);
        assert (enc_count == '0) else value_error("encoder clear", 0, enc_count);
    endtask

    task automatic sweep_commutation();
        logic [2:0] code;
        logic       dir;
        logic [2:0] src;
        logic [2:0] snk;
        int         hi_cycles;
        int         windows;
        @(posedge clk);
        en         <= 1'b0;         // Clears the fault from code 0
        hall       <= hall_seq[0];
        duty_cycle <= {1'b1, 9'd8};
        @(posedge clk);
        en <= 1'b1;

        // Soft start up to the commanded duty
        src = source_gate(hall_seq[0], 1'b1);
        wait_gates(src, "commutation ramp start");
        measure_on_time(src, hi_cycles);
        windows = 0;
        while (hi_cycles != 8 && windows < 20) begin
            measure_on_time(src, hi_cycles);
            windows++;
        end
        assert (hi_cycles == 8) else value_error("commutation ramp", 8, hi_cycles);

        for (int i = 0; i < 6; i++) begin
            for (int d = 1; d >= 0; d--) begin
                code = hall_seq[i];
                dir  = (d == 1);
                src  = source_gate(code, dir);
                snk  = sink_gate(code, dir);
                @(posedge clk);
                hall       <= code;
                duty_cycle <= {dir, 9'd8};
                wait_gates(src, "commutation source");
                hi_cycles = 0;
                repeat (pwm_max + 1) begin
                    assert ((phase_l & snk) == snk)
                        else value_error("commutation sink", snk, phase_l);
                    assert (((phase_h | phase_l) & ~(src | snk)) == 3'b000)
                        else value_error("commutation off phase", 0,
                                         (phase_h | phase_l) & ~(src | snk));
                    assert ((phase_h & ~src) == 3'b000)
                        else value_error("commutation high", src, phase_h);
                    if ((phase_h & src) != 3'b000) hi_cycles++;
                    @(negedge clk);
                end
                assert (hi_cycles == 8) else value_error("commutation on-time", 8, hi_cycles);
            end
        end
    endtask

    task automatic measure_duty_dead_time();
        logic [mag_w-1:0] mag;
        logic [31:0]      r;
        logic [2:0]       src;
        int               on_now;
        int               on_last;
        int               windows;
        r   = rand_bits(6);
        mag = 9'd16 + r[8:0];
        src = source_gate(hall_seq[5], 1'b1);
        @(posedge clk);
        duty_cycle <= {1'b1, mag};
        wait_gates(src, "duty source");
        wait_gates(3'b000, "duty pulse end");
        wait_gates(src, "duty pulse start");   // Windows line up with period starts
        on_last = -1;
        measure_on_time(src, on_now);
        windows = 0;
        while (on_now != on_last && windows < 200) begin
            on_last = on_now;
            measure_on_time(src, on_now);
            windows++;
        end
        assert (on_now == mag) else value_error("duty on-time", mag, on_now);
    endtask

    // ==================================================================
    // Sequence
    // ==================================================================
    initial begin
        lfsr_state       = 32'h5fb5_5ca4;
        arst_n           = 1'b0;
        en               = 1'b0;
        reset_enc_count  = 1'b0;
        reset_hall_count = 1'b0;
        duty_cycle       = '0;
        enc              = 2'b00;
        hall             = 3'd0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        verify_reset_disable();
        step_hall_sensors();
        count_encoder_steps();
        sweep_commutation();
        measure_duty_dead_time();

        assert (falls_checked > 0)
            else text_error("No high-side fall reached the dead-time check");
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== bldc_motor.f ====
rtl/bldc_pkg.sv
rtl/hall_bus_if.sv
rtl/hall_monitor.sv
rtl/encoder_counter.sv
rtl/phase_driver.sv
rtl/bldc_motor.sv
dv/bldc_motor_tb.sv

// ==== Makefile ====
# Verilator build and run for the BLDC motor controller testbench
TOP := bldc_motor_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f bldc_motor.f \
		--top-module $(TOP) -o V$(TOP)

# The log decides the verdict, a fail line or a missing pass line fails the run
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
